// File: verilog/ifu_pkg.sv
//**************************************
// ICCM is the only fetch source; it holds ICCM_WORDS 32-bit words from address 0
//**************************************
package ifu_pkg;

   //**************************************
   // Memory and address sizes
   //**************************************
   localparam int ICCM_WORDS = 256;                          // 32-bit words in ICCM
   localparam int ICCM_AW    = $clog2(ICCM_WORDS);           // Word address width
   localparam int PC_W       = 32;                           // Program counter width

   localparam logic [PC_W-1:0] ICCM_BYTES = PC_W'(ICCM_WORDS * 4); // First faulting byte
   localparam logic [PC_W-1:0] RESET_PC   = '0;              // First fetch after reset

   //**************************************
   // Halfword queue sizes
   //**************************************
   localparam int BUF_HW   = 8;                              // Queue depth in halfwords
   localparam int BUF_PW   = $clog2(BUF_HW);                 // Queue pointer width
   localparam int HW_CNT_W = $clog2(BUF_HW + 1);             // Holds 0..BUF_HW

   // Fetch control state
   typedef enum logic [0:0] {
      FS_FETCH = 1'b0,                                       // Sequential fetch
      FS_HALT  = 1'b1                                        // Idle until next flush
   } fetch_state_t;

   // Opcode quadrant, instr[1:0]
   typedef enum logic [1:0] {
      Q0 = 2'b00,                                            // Compressed
      Q1 = 2'b01,                                            // Compressed
      Q2 = 2'b10,                                            // Compressed
      Q3 = 2'b11                                             // Full 32-bit
   } rv_quad_t;

endpackage

// File: verilog/ifu_ifaces.sv
//**************************************
// A request on fetch_req_if is always taken; fetch control gates it by free_hw
//**************************************

// Fetch control to fetch buffer
interface fetch_req_if;
   import ifu_pkg::*;

   logic                req_valid;      // Request on the ICCM this cycle
   logic [PC_W-1:1]     req_pc;         // Halfword address of request
   logic                req_fault;      // Out of ICCM, not read
   logic                flush;          // One-cycle queue clear
   logic [HW_CNT_W-1:0] free_hw;        // Empty queue slots

   modport ctl (
      output req_valid,
      output req_pc,
      output req_fault,
      output flush,
      input  free_hw
   );

   modport fbuf (
      input  req_valid,
      input  req_pc,
      input  req_fault,
      input  flush,
      output free_hw
   );
endinterface

// Fetch buffer to aligner
interface aln_if;
   import ifu_pkg::*;

   logic [1:0]      hw_valid;           // Bit 0 oldest halfword
   logic [15:0]     hw0;                // Oldest halfword
   logic [15:0]     hw1;                // Next halfword
   logic [1:0]      hw_fault;           // Per-halfword access fault
   logic [PC_W-1:1] head_pc;            // Address of hw0
   logic [1:0]      consume;            // One-hot, pop 1 or 2

   modport fbuf (
      output hw_valid,
      output hw0,
      output hw1,
      output hw_fault,
      output head_pc,
      input  consume
   );

   modport aln (
      input  hw_valid,
      input  hw0,
      input  hw1,
      input  hw_fault,
      input  head_pc,
      output consume
   );
endinterface

// File: verilog/ifu_fetch_ctl.sv
//**************************************
// One request per cycle at most; a fault or a no-redirect flush halts fetch
// until the next flush; the queue must leave room for two halfwords past in-flight
//**************************************
module ifu_fetch_ctl (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        exu_flush_final,       // Redirect, one cycle
   input  logic                        exu_flush_noredir,     // Flush without refetch
   input  logic [31:1]                 exu_flush_path_final,  // Redirect target
   output logic                        iccm_rden,
   output logic [ifu_pkg::ICCM_AW-1:0] iccm_addr,
   fetch_req_if.ctl                    req
);
   import ifu_pkg::*;

   fetch_state_t        state;
   logic [PC_W-1:1]     fetch_pc;       // Next sequential word
   logic [PC_W-1:1]     next_pc;        // Address of the request being decided
   logic                next_fault;     // Decided request is outside ICCM
   logic                issue;          // Request goes out next cycle
   logic [HW_CNT_W-1:0] cur_hw;         // Halfwords of request on the bus now
   logic [HW_CNT_W-1:0] prev_hw;        // Halfwords of request returning now
   logic [HW_CNT_W-1:0] inflight;
   logic                room;
   logic                req_valid_q;
   logic [PC_W-1:1]     req_pc_q;
   logic                req_fault_q;

   //**************************************
   // Fetch decision
   //**************************************
   always_comb begin
      next_pc    = exu_flush_final ? exu_flush_path_final : fetch_pc;
      next_fault = ({next_pc, 1'b0} >= ICCM_BYTES);            // Region check
      cur_hw     = '0;
      if (req_valid_q) begin
         // Fault or odd halfword start pushes a single entry
         cur_hw = (req_fault_q | req_pc_q[1]) ? HW_CNT_W'(1) : HW_CNT_W'(2);
      end
      inflight = cur_hw + prev_hw;
      room     = (req.free_hw >= inflight + HW_CNT_W'(2));
      if (exu_flush_final) begin
         issue = ~exu_flush_noredir;                            // Queue empties on flush
      end else begin
         issue = (state == FS_FETCH) & room;
      end
   end

   //**************************************
   // State and request registers
   //**************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= FS_FETCH;
         fetch_pc    <= RESET_PC[PC_W-1:1];
         req_valid_q <= 1'b0;
         prev_hw     <= '0;
      end else begin
         req_valid_q <= issue;
         prev_hw     <= exu_flush_final ? '0 : cur_hw;          // Flushed read is dropped
         if (exu_flush_final & exu_flush_noredir) begin
            state <= FS_HALT;
         end else if (issue) begin
            state    <= next_fault ? FS_HALT : FS_FETCH;
            fetch_pc <= {next_pc[PC_W-1:2] + 1'b1, 1'b0};       // Next word, aligned
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         req_pc_q    <= next_pc;
         req_fault_q <= next_fault;
      end
   end

   assign req.req_valid = req_valid_q;
   assign req.req_pc    = req_pc_q;
   assign req.req_fault = req_fault_q;
   assign req.flush     = exu_flush_final;
   assign iccm_rden     = req_valid_q & ~req_fault_q;          // Faulted fetch not read
   assign iccm_addr     = req_pc_q[ICCM_AW+1:2];

endmodule

// File: verilog/ifu_fetch_buf.sv
//**************************************
// ICCM data is taken one cycle after the request; the queue never overflows
// because fetch control reserves space for reads in flight
//**************************************
module ifu_fetch_buf (
   input  logic        clk,
   input  logic        rst,
   input  logic [31:0] iccm_rd_data,          // Returns the cycle after iccm_rden
   fetch_req_if.fbuf   req,
   aln_if.fbuf         aln
);
   import ifu_pkg::*;

   logic                rec_valid;            // Read returning this cycle
   logic [PC_W-1:1]     rec_pc;
   logic                rec_fault;
   logic [15:0]         q_data  [BUF_HW];
   logic                q_fault [BUF_HW];
   logic [BUF_PW-1:0]   rd_ptr;
   logic [BUF_PW-1:0]   rd_nxt;
   logic [BUF_PW-1:0]   wr_ptr;
   logic [BUF_PW-1:0]   wr_nxt;
   logic [HW_CNT_W-1:0] count;                // Valid halfwords
   logic [HW_CNT_W-1:0] push_n;
   logic [HW_CNT_W-1:0] pop_n;
   logic [HW_CNT_W-1:0] left_n;               // Entries left after pop
   logic [15:0]         push_hw0;
   logic [15:0]         push_hw1;
   logic [PC_W-1:1]     head_pc;

   //**************************************
   // Outstanding read record
   //**************************************
   always_ff @(posedge clk) begin
      if (rst | req.flush) begin
         rec_valid <= 1'b0;                   // Drop the read in flight
      end else begin
         rec_valid <= req.req_valid;
      end
   end

   always_ff @(posedge clk) begin
      rec_pc    <= req.req_pc;
      rec_fault <= req.req_fault;
   end

   // Push and pop sizes
   always_comb begin
      push_n = '0;
      if (rec_valid) begin
         push_n = (rec_fault | rec_pc[1]) ? HW_CNT_W'(1) : HW_CNT_W'(2);
      end
      if (rec_fault) begin
         push_hw0 = '0;                       // Fault carries no data
      end else if (rec_pc[1]) begin
         push_hw0 = iccm_rd_data[31:16];      // Upper half only
      end else begin
         push_hw0 = iccm_rd_data[15:0];
      end
      push_hw1 = iccm_rd_data[31:16];
      if (aln.consume[1]) begin
         pop_n = HW_CNT_W'(2);
      end else if (aln.consume[0]) begin
         pop_n = HW_CNT_W'(1);
      end else begin
         pop_n = '0;
      end
      left_n = count - pop_n;
   end

   assign rd_nxt = rd_ptr + 1'b1;
   assign wr_nxt = wr_ptr + 1'b1;

   //**************************************
   // Halfword queue
   //**************************************
   always_ff @(posedge clk) begin
      if (push_n != '0) begin
         q_data[wr_ptr]  <= push_hw0;
         q_fault[wr_ptr] <= rec_fault;
      end
      if (push_n == HW_CNT_W'(2)) begin
         q_data[wr_nxt]  <= push_hw1;
         q_fault[wr_nxt] <= 1'b0;             // Two-entry push is never a fault
      end
   end

   always_ff @(posedge clk) begin
      if (rst | req.flush) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         rd_ptr <= rd_ptr + BUF_PW'(pop_n);
         wr_ptr <= wr_ptr + BUF_PW'(push_n);
         count  <= left_n + push_n;
      end
   end

   // Head address follows pops; an empty queue restarts at the new read
   always_ff @(posedge clk) begin
      if (rst) begin
         head_pc <= RESET_PC[PC_W-1:1];
      end else if ((left_n == '0) && (push_n != '0)) begin
         head_pc <= rec_pc;
      end else begin
         head_pc <= head_pc + (PC_W-1)'(pop_n);
      end
   end

   assign aln.hw_valid = {count >= HW_CNT_W'(2), count != '0};
   assign aln.hw0      = q_data[rd_ptr];
   assign aln.hw1      = q_data[rd_nxt];
   assign aln.hw_fault = {q_fault[rd_nxt], q_fault[rd_ptr]};
   assign aln.head_pc  = head_pc;
   assign req.free_hw  = HW_CNT_W'(BUF_HW) - count;

endmodule

// File: verilog/ifu_aligner.sv
//**************************************
// Combinational; outputs change only when the queue head changes
//**************************************
module ifu_aligner (
   input  logic        dec_i0_decode_d,    // Decode ready
   aln_if.aln          aln,
   output logic        ifu_i0_valid,
   output logic [31:0] ifu_i0_instr,
   output logic [31:1] ifu_i0_pc,
   output logic        ifu_i0_pc4,         // 32-bit instruction
   output logic        ifu_i0_icaf         // Access fault on any used half
);
   import ifu_pkg::*;

   rv_quad_t quad;
   logic     is32;
   logic     fault;
   logic     xfer;

   //**************************************
   // Length and fault decode
   //**************************************
   always_comb begin
      quad = rv_quad_t'(aln.hw0[1:0]);
      case (quad)
         Q0, Q1, Q2: is32 = 1'b0;
         Q3:         is32 = 1'b1;
         default:    is32 = 1'b0;
      endcase
      // Faulted hw0 has no valid opcode, treat as 2 bytes
      if (aln.hw_fault[0]) begin
         is32 = 1'b0;
      end
      fault = aln.hw_fault[0] | (is32 & aln.hw_fault[1]);
   end

   //**************************************
   // Decode outputs
   //**************************************
   always_comb begin
      ifu_i0_valid = is32 ? (&aln.hw_valid) : aln.hw_valid[0];  // 32-bit waits for hw1
      if (fault) begin
         ifu_i0_instr = '0;
      end else if (is32) begin
         ifu_i0_instr = {aln.hw1, aln.hw0};
      end else begin
         ifu_i0_instr = {16'h0000, aln.hw0};
      end
      ifu_i0_pc   = aln.head_pc;
      ifu_i0_pc4  = is32;
      ifu_i0_icaf = fault;
   end

   assign xfer        = ifu_i0_valid & dec_i0_decode_d;         // Handshake with decode
   assign aln.consume = {xfer & is32, xfer & ~is32};

endmodule

// File: verilog/ifu_top.sv
//**************************************
// ICCM read latency is one cycle; decode may stall with dec_i0_decode_d low
//**************************************
module ifu_top (
   input  logic                        clk,
   input  logic                        rst,                   // Synchronous, active high
   input  logic                        exu_flush_final,
   input  logic                        exu_flush_noredir,
   input  logic [31:1]                 exu_flush_path_final,
   input  logic                        dec_i0_decode_d,
   input  logic [31:0]                 iccm_rd_data,
   output logic                        iccm_rden,
   output logic [ifu_pkg::ICCM_AW-1:0] iccm_addr,
   output logic                        ifu_i0_valid,
   output logic [31:0]                 ifu_i0_instr,
   output logic [31:1]                 ifu_i0_pc,
   output logic                        ifu_i0_pc4,
   output logic                        ifu_i0_icaf
);

   fetch_req_if u_req ();                 // Control to buffer
   aln_if       u_aln ();                 // Buffer to aligner

   //**************************************
   // Fetch control, queue and aligner
   //**************************************
   ifu_fetch_ctl u_fetch_ctl (
      .clk                  (clk),
      .rst                  (rst),
      .exu_flush_final      (exu_flush_final),
      .exu_flush_noredir    (exu_flush_noredir),
      .exu_flush_path_final (exu_flush_path_final),
      .iccm_rden            (iccm_rden),
      .iccm_addr            (iccm_addr),
      .req                  (u_req)
   );

   ifu_fetch_buf u_fetch_buf (
      .clk                  (clk),
      .rst                  (rst),
      .iccm_rd_data         (iccm_rd_data),
      .req                  (u_req),
      .aln                  (u_aln)
   );

   ifu_aligner u_aligner (
      .dec_i0_decode_d      (dec_i0_decode_d),
      .aln                  (u_aln),
      .ifu_i0_valid         (ifu_i0_valid),
      .ifu_i0_instr         (ifu_i0_instr),
      .ifu_i0_pc            (ifu_i0_pc),
      .ifu_i0_pc4           (ifu_i0_pc4),
      .ifu_i0_icaf          (ifu_i0_icaf)
   );

endmodule

// File: test/tb_clock.sv
//**************************************
// Free-running clock, starts low at time 0
//**************************************
module tb_clock #(
   parameter int PERIOD = 100                // Full clock period
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

// File: test/ifu_sva.sv
//**************************************
// Bound into ifu_top; the stall check skips flush cycles, which empty the queue
//**************************************
module ifu_sva (
   input logic                        clk,
   input logic                        rst,
   input logic                        exu_flush_final,
   input logic                        dec_i0_decode_d,
   input logic                        iccm_rden,
   input logic [ifu_pkg::ICCM_AW-1:0] iccm_addr,
   input logic [31:1]                 req_pc,       // Full address of the read
   input logic                        ifu_i0_valid,
   input logic [31:0]                 ifu_i0_instr,
   input logic [31:1]                 ifu_i0_pc,
   input logic                        ifu_i0_pc4,
   input logic                        ifu_i0_icaf
);
   import ifu_pkg::*;

   // Read must not wrap past the end of ICCM
   a_addr_range: assert property (@(posedge clk) disable iff (rst)
      iccm_rden |-> (!$isunknown(iccm_addr) && ({req_pc, 1'b0} < ICCM_BYTES)))
      else $error("ICCM read address outside the memory");

   // Offered instruction frozen until decode takes it
   a_hold_stall: assert property (@(posedge clk) disable iff (rst)
      (ifu_i0_valid && !dec_i0_decode_d && !exu_flush_final) |=>
         (ifu_i0_valid && $stable(ifu_i0_instr) && $stable(ifu_i0_pc) &&
          $stable(ifu_i0_pc4) && $stable(ifu_i0_icaf)))
      else $error("ifu_i0 outputs changed while decode was stalled");

   a_reset_quiet: assert property (@(posedge clk)
      rst |=> (!iccm_rden && !ifu_i0_valid))              // Also first cycle after rst
      else $error("ICCM read or decode valid during reset");

endmodule

bind ifu_top ifu_sva u_sva (
   .clk             (clk),
   .rst             (rst),
   .exu_flush_final (exu_flush_final),
   .dec_i0_decode_d (dec_i0_decode_d),
   .iccm_rden       (iccm_rden),
   .iccm_addr       (iccm_addr),
   .req_pc          (u_req.req_pc),
   .ifu_i0_valid    (ifu_i0_valid),
   .ifu_i0_instr    (ifu_i0_instr),
   .ifu_i0_pc       (ifu_i0_pc),
   .ifu_i0_pc4      (ifu_i0_pc4),
   .ifu_i0_icaf     (ifu_i0_icaf)
);

// File: test/tb_ifu.sv
//**************************************
// ICCM model answers one cycle after iccm_rden; decode is held off in flush cycles
//**************************************
module tb_ifu;
   import ifu_pkg::*;

   localparam int N_T1 = 200;                    // Instructions per test
   localparam int N_T2 = 60;
   localparam int N_T3 = 200;
   localparam int N_T4 = 48;
   localparam int N_T5 = 50;
   localparam int WATCHDOG_CYCLES = (N_T1 + N_T2 + N_T3 + N_T4 + N_T5) * 20;

   logic               clk;
   logic               rst;
   logic               exu_flush_final;
   logic               exu_flush_noredir;
   logic [31:1]        exu_flush_path_final;
   logic               dec_i0_decode_d;
   logic [31:0]        iccm_rd_data;
   logic               iccm_rden;
   logic [ICCM_AW-1:0] iccm_addr;
   logic               ifu_i0_valid;
   logic [31:0]        ifu_i0_instr;
   logic [31:1]        ifu_i0_pc;
   logic               ifu_i0_pc4;
   logic               ifu_i0_icaf;

   logic [31:0]        mem [ICCM_WORDS];         // ICCM contents
   logic               rd_pend;                  // Read returns this cycle
   logic [ICCM_AW-1:0] rd_addr;
   logic               redir_pend = 1'b0;        // Read at flush target due now
   logic [ICCM_AW-1:0] redir_addr;
   int unsigned        rnd = 98350;              // LCG state, seed
   logic               stall_mode = 1'b0;        // Random decode back-pressure
   logic [31:0]        exp_pc;                   // Byte address of next expected instr
   logic               halted;                   // No transfer allowed until a flush
   logic               last_fault_pc4;
   logic [31:0]        e_instr;
   logic               e_pc4;
   logic               e_icaf;
   logic [31:0]        e_next;
   int                 xfer_count = 0;
   int                 fault_count = 0;
   int                 err_count = 0;
   int                 test_count = 0;
   int                 err0 = 0;                 // Counts at start of current test
   int                 xfer0 = 0;

   tb_clock #(.PERIOD(100)) u_clock (.clk(clk));

   ifu_top dut (.*);

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   //**************************************
   // Reference fetch model
   //**************************************
   function automatic void ref_fetch(
      input  logic [31:0] pc,
      input  logic [31:0] m [ICCM_WORDS],
      output logic [31:0] instr,
      output logic        pc4,
      output logic        icaf,
      output logic [31:0] next_pc
   );
      logic [31:0] hi_pc;
      logic [15:0] lo;
      logic [15:0] hi;
      hi_pc   = pc + 32'd2;
      instr   = '0;
      pc4     = 1'b0;
      icaf    = 1'b0;
      next_pc = pc + 32'd2;
      if (pc >= ICCM_BYTES) begin
         icaf = 1'b1;                             // Whole instruction past the end
      end else begin
         lo = pc[1] ? m[pc[ICCM_AW+1:2]][31:16] : m[pc[ICCM_AW+1:2]][15:0];
         if (lo[1:0] != 2'b11) begin
            instr = {16'h0000, lo};
         end else begin
            pc4     = 1'b1;
            next_pc = pc + 32'd4;
            if (hi_pc >= ICCM_BYTES) begin
               icaf = 1'b1;                       // Upper half past the end
            end else begin
               hi    = hi_pc[1] ? m[hi_pc[ICCM_AW+1:2]][31:16] : m[hi_pc[ICCM_AW+1:2]][15:0];
               instr = {hi, lo};
            end
         end
      end
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at time %0t: %s got %h expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   // ICCM model, data driven on the falling edge of the return cycle
   always @(posedge clk) begin
      rd_pend <= iccm_rden;
      rd_addr <= iccm_addr;
   end

   always @(negedge clk) begin
      if (rd_pend) begin
         iccm_rd_data = mem[rd_addr];
      end
   end

   // Redirected read goes out in the cycle after the flush
   always @(posedge clk) begin
      if (redir_pend) begin
         check("iccm_rden after flush", 32'(iccm_rden), 32'd1);
         check("iccm_addr after flush", 32'(iccm_addr), 32'(redir_addr));
      end
      redir_pend <= ~rst & exu_flush_final & ~exu_flush_noredir &
                    ({exu_flush_path_final, 1'b0} < ICCM_BYTES);
      redir_addr <= exu_flush_path_final[ICCM_AW+1:2];
   end

   //**************************************
   // Transfer checker
   //**************************************
   always @(posedge clk) begin
      if (rst) begin
         exp_pc = RESET_PC;
         halted = 1'b0;
      end else if (exu_flush_final) begin
         exp_pc = {exu_flush_path_final, 1'b0};
         halted = exu_flush_noredir;
      end else if (halted) begin
         if (ifu_i0_valid) begin
            check("ifu_i0_valid while halted", 32'(ifu_i0_valid), 32'd0);
         end
      end else if (ifu_i0_valid && dec_i0_decode_d) begin
         ref_fetch(exp_pc, mem, e_instr, e_pc4, e_icaf, e_next);
         check("ifu_i0_pc", {ifu_i0_pc, 1'b0}, exp_pc);
         check("ifu_i0_instr", ifu_i0_instr, e_instr);
         check("ifu_i0_pc4", 32'(ifu_i0_pc4), 32'(e_pc4));
         check("ifu_i0_icaf", 32'(ifu_i0_icaf), 32'(e_icaf));
         xfer_count++;
         if (e_icaf) begin
            halted         = 1'b1;                // Stream ends at the fault
            last_fault_pc4 = ifu_i0_pc4;
            fault_count++;
         end
         exp_pc = e_next;
      end
   end

   task automatic drive_cycle();
      @(negedge clk);
      exu_flush_final   = 1'b0;
      exu_flush_noredir = 1'b0;
      rnd               = lcg_next(rnd);
      dec_i0_decode_d   = stall_mode ? rnd[16] : 1'b1;
   endtask

   task automatic flush_to(input logic [31:0] target, input logic noredir);
      @(negedge clk);
      exu_flush_final      = 1'b1;
      exu_flush_noredir    = noredir;
      exu_flush_path_final = target[31:1];
      dec_i0_decode_d      = 1'b0;               // No transfer in the flush cycle
   endtask

   task automatic run_instrs(input int n);
      int target;
      int cycles;
      target = xfer_count + n;
      cycles = 0;
      while (xfer_count < target && cycles < n * 20) begin
         drive_cycle();
         cycles++;
      end
      if (xfer_count < target) begin
         $display("Timeout: %0d of %0d instructions never reached decode",
                  target - xfer_count, n);
         err_count++;
      end
   endtask

   // Runs to the access fault, then idles so a late valid is caught
   task automatic run_to_fault();
      int f0;
      int cycles;
      f0     = fault_count;
      cycles = 0;
      while (fault_count == f0 && cycles < 320) begin
         drive_cycle();
         cycles++;
      end
      if (fault_count == f0) begin
         $display("No access fault reached decode within %0d cycles", cycles);
         err_count++;
      end
      repeat (20) drive_cycle();
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("test %0d %s: %0d transfers, %0d errors", test_count, name,
               xfer_count - xfer0, err_count - err0);
      err0  = err_count;
      xfer0 = xfer_count;
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("sim failed");
      $finish;
   end

   //**************************************
   // Test sequence
   //**************************************
   initial begin
      rst                  = 1'b1;
      exu_flush_final      = 1'b0;
      exu_flush_noredir    = 1'b0;
      exu_flush_path_final = '0;
      dec_i0_decode_d      = 1'b0;
      iccm_rd_data         = '0;
      for (int i = 0; i < ICCM_WORDS; i++) begin
         rnd            = lcg_next(rnd);
         mem[i][15:0]   = rnd[30:15];
         rnd            = lcg_next(rnd);
         mem[i][31:16]  = rnd[30:15];
      end
      repeat (2) @(negedge clk);
      rst = 1'b0;

      run_instrs(N_T1);
      end_test("stream from reset");

      for (int i = 0; i < 3; i++) begin           // Targets all have pc bit 1 set
         flush_to(32'h1A2 + 32'(i) * 32'h0A4, 1'b0);
         run_instrs(N_T2 / 3);
      end
      end_test("flush redirect");

      stall_mode = 1'b1;
      flush_to(32'h2, 1'b0);
      run_instrs(N_T3);
      stall_mode = 1'b0;
      end_test("decode back-pressure");

      flush_to(ICCM_BYTES - 32'd24, 1'b0);
      run_to_fault();
      mem[ICCM_WORDS-1][17:16] = 2'b11;           // Last halfword starts a 32-bit instr
      flush_to(ICCM_BYTES - 32'd2, 1'b0);
      run_to_fault();
      check("pc4 of split fault", 32'(last_fault_pc4), 32'd1);
      mem[ICCM_WORDS-1][17:16] = 2'b01;           // Last halfword compressed
      flush_to(ICCM_BYTES - 32'd2, 1'b0);
      run_to_fault();
      check("pc4 of end fault", 32'(last_fault_pc4), 32'd0);
      end_test("end of ICCM");

      flush_to(32'h40, 1'b0);
      run_instrs(10);
      flush_to(32'h100, 1'b1);
      repeat (50) drive_cycle();
      flush_to(32'h0C6, 1'b0);
      run_instrs(N_T5 - 10);
      end_test("no-redirect flush");

      $display("%0d tests, %0d transfers, %0d errors", test_count, xfer_count, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: sources.f
verilog/ifu_pkg.sv
verilog/ifu_ifaces.sv
verilog/ifu_fetch_ctl.sv
verilog/ifu_fetch_buf.sv
verilog/ifu_aligner.sv
verilog/ifu_top.sv
test/tb_clock.sv
test/ifu_sva.sv
test/tb_ifu.sv

// File: Makefile
# Verilator build and run for the ICCM fetch unit

SIM        = verilator
TOP        = tb_ifu
FILELIST   = sources.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "sim passed" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
